//--- backend_alu.sv
`timescale 1ns/1ps
`include "backend_params.svh"

module backend_alu (
    input  backend_pkg::op_e  op_i,
    input  logic [`XLEN-1:0]  pc_i,
    input  logic [`XLEN-1:0]  imm_i,
    input  logic [`XLEN-1:0]  rs1_i,
    input  logic [`XLEN-1:0]  rs2_i,

    output logic [`XLEN-1:0]  result_o,
    output logic [`XLEN-1:0]  target_o,
    output logic              equal_o
);

    import backend_pkg::*;

    logic [`XLEN-1:0] link;

    assign link = pc_i + `XLEN'(4);

    always_comb begin
        unique case (op_i)
            OP_ADD:  result_o = rs1_i + rs2_i;
            OP_SUB:  result_o = rs1_i - rs2_i;
            OP_AND:  result_o = rs1_i & rs2_i;
            OP_OR:   result_o = rs1_i | rs2_i;
            OP_XOR:  result_o = rs1_i ^ rs2_i;
            OP_ADDI: result_o = rs1_i + imm_i;
            // Jumps and branches write the return address
            OP_BEQ,
            OP_JAL:  result_o = link;
            // MUL takes its result from the multiplier
            default: result_o = '0;
        endcase
    end

    // Branch and jump target, both PC relative
    assign target_o = pc_i + imm_i;
    assign equal_o  = rs1_i == rs2_i;

endmodule

//--- backend_checker.sv
`timescale 1ns/1ps
`include "backend_params.svh"

module backend_checker (
    input logic                 clk_i,
    input logic                 rst_ni,
    input logic                 commit_valid_i,
    input backend_pkg::commit_t commit_i,
    input logic                 redirect_valid_i,
    input logic [`XLEN-1:0]     redirect_pc_i
);

    import backend_pkg::*;

    logic [`XLEN-1:0]   exp_pc    [$];
    logic [`REG_AW-1:0] exp_rd    [$];
    logic [`XLEN-1:0]   exp_data  [$];
    logic [`XLEN-1:0]   exp_redir [$];
    string              test_name;
    int                 seen_count;
    int                 redir_count;
    int                 test_errors;
    int                 error_total;
    int                 tests_run;
    int                 tests_failed;

    initial begin
        seen_count   = 0;
        redir_count  = 0;
        test_errors  = 0;
        error_total  = 0;
        tests_run    = 0;
        tests_failed = 0;
    end

    task automatic start_test(input string name);
        test_name = name;
        exp_pc.delete();
        exp_rd.delete();
        exp_data.delete();
        exp_redir.delete();
        seen_count  = 0;
        redir_count = 0;
        test_errors = 0;
    endtask

    task automatic add_expect(input logic [`XLEN-1:0] pc, input logic [`REG_AW-1:0] rd,
                              input logic [`XLEN-1:0] data);
        // A commit that does not follow its predecessor is a redirect target
        if (exp_pc.size() > 0 && pc != exp_pc[exp_pc.size()-1] + `XLEN'(4)) begin
            exp_redir.push_back(pc);
        end
        exp_pc.push_back(pc);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
    endtask

    //////////////////////////////
    // Commit compare
    //////////////////////////////

    always @(posedge clk_i) begin
        if (rst_ni && commit_valid_i) begin
            if (seen_count >= exp_pc.size()) begin
                $display("Test %s got an extra commit from pc %h that was not expected",
                         test_name, commit_i.pc);
                test_errors++;
            end
            else begin
                if (commit_i.pc !== exp_pc[seen_count]) begin
                    $display("Error at time %0t: test %s commit %0d pc is %h, expected %h",
                             $time, test_name, seen_count, commit_i.pc, exp_pc[seen_count]);
                    test_errors++;
                end
                if (commit_i.rd !== exp_rd[seen_count]) begin
                    $display("Error at time %0t: test %s commit %0d rd is %0d, expected %0d",
                             $time, test_name, seen_count, commit_i.rd, exp_rd[seen_count]);
                    test_errors++;
                end
                if (commit_i.data !== exp_data[seen_count]) begin
                    $display("Error at time %0t: test %s commit %0d data is %h, expected %h",
                             $time, test_name, seen_count, commit_i.data,
                             exp_data[seen_count]);
                    test_errors++;
                end
            end
            seen_count++;
        end
    end

    //////////////////////////////
    // Redirect compare
    //////////////////////////////

    always @(posedge clk_i) begin
        if (rst_ni && redirect_valid_i) begin
            if (redir_count >= exp_redir.size()) begin
                $display("Test %s got an unexpected redirect to %h", test_name, redirect_pc_i);
                test_errors++;
            end
            else if (redirect_pc_i !== exp_redir[redir_count]) begin
                $display("Error at time %0t: test %s redirect %0d pc is %h, expected %h",
                         $time, test_name, redir_count, redirect_pc_i,
                         exp_redir[redir_count]);
                test_errors++;
            end
            redir_count++;
        end
    end

    task automatic end_test();
        if (seen_count < exp_pc.size()) begin
            $display("Test %s is missing %0d of its expected commits",
                     test_name, exp_pc.size() - seen_count);
            test_errors++;
        end
        if (redir_count < exp_redir.size()) begin
            $display("Test %s is missing %0d of its expected redirects",
                     test_name, exp_redir.size() - redir_count);
            test_errors++;
        end
        if (test_errors == 0) begin
            $display("PASS %s (%0d commits)", test_name, seen_count);
        end
        else begin
            $display("FAIL %s (%0d errors)", test_name, test_errors);
            tests_failed++;
        end
        error_total += test_errors;
        tests_run++;
    endtask

    task automatic print_summary();
        $display("Summary: %0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, error_total);
    endtask

endmodule

//--- backend_exec_pipe.sv
`timescale 1ns/1ps
`include "backend_params.svh"

module backend_exec_pipe (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    input  logic                 issue_i,
    input  backend_pkg::instr_t  instr_i,
    input  logic [`XLEN-1:0]     alu_result_i,
    input  logic                 mul_done_i,
    input  logic [`XLEN-1:0]     mul_product_i,

    // Stage status for bypass and hazards
    output logic                 ex1_pending_o,
    output logic                 ex1_data_valid_o,
    output logic [`REG_AW-1:0]   ex1_rd_o,
    output logic [`XLEN-1:0]     ex1_data_o,
    output logic                 ex2_pending_o,
    output logic                 ex2_data_valid_o,
    output logic [`REG_AW-1:0]   ex2_rd_o,
    output logic [`XLEN-1:0]     ex2_data_o,
    output logic                 ex1_ready_o,

    // Writeback
    output logic                 rf_we_o,
    output logic [`REG_AW-1:0]   rf_waddr_o,
    output logic [`XLEN-1:0]     rf_wdata_o,
    output logic                 commit_valid_o,
    output backend_pkg::commit_t commit_o
);

    import backend_pkg::*;

    typedef struct packed {
        logic               pending;
        logic [`XLEN-1:0]   pc;
        logic [`REG_AW-1:0] rd;
        fu_e                sel;
        logic [`XLEN-1:0]   data;
    } stage_t;

    stage_t ex1_q;
    stage_t ex1_d;
    stage_t ex2_q;
    stage_t ex2_d;
    logic   ex2_ready;

    // At most one MUL is in flight, so the done strobe is for whichever stage waits on it
    assign ex1_data_valid_o = ex1_q.sel == FU_ALU || mul_done_i;
    assign ex1_data_o       = (ex1_q.sel == FU_ALU) ? ex1_q.data : mul_product_i;
    assign ex2_data_valid_o = ex2_q.sel == FU_ALU || mul_done_i;
    assign ex2_data_o       = (ex2_q.sel == FU_ALU) ? ex2_q.data : mul_product_i;

    assign ex1_pending_o = ex1_q.pending;
    assign ex1_rd_o      = ex1_q.rd;
    assign ex2_pending_o = ex2_q.pending;
    assign ex2_rd_o      = ex2_q.rd;

    assign ex2_ready   = !ex2_q.pending || ex2_data_valid_o;
    assign ex1_ready_o = ex2_ready || !ex1_q.pending;

    //////////////////////////////
    // EX1
    //////////////////////////////

    always_comb begin
        ex1_d = ex1_q;

        // Keep a result that arrived while EX2 is stalled
        if (ex1_data_valid_o) begin
            ex1_d.sel  = FU_ALU;
            ex1_d.data = ex1_data_o;
        end

        if (ex2_ready) begin
            ex1_d.pending = 1'b0;
            ex1_d.sel     = FU_ALU;
        end

        if (issue_i) begin
            ex1_d.pending = 1'b1;
            ex1_d.pc      = instr_i.pc;
            ex1_d.rd      = instr_i.rd;
            ex1_d.sel     = (instr_i.op == OP_MUL) ? FU_MUL : FU_ALU;
            ex1_d.data    = alu_result_i;
        end
    end

    //////////////////////////////
    // EX2
    //////////////////////////////

    always_comb begin
        ex2_d = ex2_q;

        // Retire
        if (ex2_data_valid_o) begin
            ex2_d.pending = 1'b0;
            ex2_d.sel     = FU_ALU;
        end

        if (ex1_q.pending && ex2_ready) begin
            ex2_d = ex1_q;
            if (ex1_data_valid_o) begin
                ex2_d.sel  = FU_ALU;
                ex2_d.data = ex1_data_o;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex1_q <= '0;
            ex2_q <= '0;
        end
        else begin
            ex1_q <= ex1_d;
            ex2_q <= ex2_d;
        end
    end

    assign rf_we_o    = ex2_q.pending && ex2_data_valid_o;
    assign rf_waddr_o = ex2_q.rd;
    assign rf_wdata_o = ex2_data_o;

    assign commit_valid_o = rf_we_o;
    assign commit_o = '{pc: ex2_q.pc, rd: ex2_q.rd, data: ex2_data_o};

endmodule

//--- backend_issue.sv
`timescale 1ns/1ps
`include "backend_params.svh"

module backend_issue (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    // Frontend
    input  logic                 fetch_valid_i,
    output logic                 fetch_ready_o,
    input  backend_pkg::instr_t  fetch_instr_i,

    // Register file read
    input  logic [`XLEN-1:0]     rf_rdata_a_i,
    input  logic [`XLEN-1:0]     rf_rdata_b_i,
    output logic [`REG_AW-1:0]   rf_raddr_a_o,
    output logic [`REG_AW-1:0]   rf_raddr_b_o,

    // Execute stage status
    input  logic                 ex1_pending_i,
    input  logic                 ex1_data_valid_i,
    input  logic [`REG_AW-1:0]   ex1_rd_i,
    input  logic [`XLEN-1:0]     ex1_data_i,
    input  logic                 ex2_pending_i,
    input  logic                 ex2_data_valid_i,
    input  logic [`REG_AW-1:0]   ex2_rd_i,
    input  logic [`XLEN-1:0]     ex2_data_i,
    input  logic                 ex1_ready_i,

    input  logic                 mul_busy_i,
    input  logic [`XLEN-1:0]     alu_target_i,
    input  logic                 alu_equal_i,

    // Issued instruction
    output backend_pkg::instr_t  instr_o,
    output logic [`XLEN-1:0]     rs1_o,
    output logic [`XLEN-1:0]     rs2_o,
    output logic                 issue_o,

    output logic                 redirect_valid_o,
    output logic [`XLEN-1:0]     redirect_pc_o
);

    import backend_pkg::*;

    logic             iss_valid_q;
    instr_t           iss_instr_q;
    issue_state_e     state_q;
    issue_state_e     state_d;
    logic [`XLEN-1:0] exp_pc_q;
    logic [`XLEN-1:0] exp_pc_d;
    logic [`XLEN-1:0] npc;
    logic [`XLEN:0]   fwd_a;
    logic [`XLEN:0]   fwd_b;
    logic             pc_mismatch;
    logic             data_hazard;
    logic             struct_hazard;
    logic             control_hazard;
    logic             iss_ready;
    logic             ex_issue;

    // Top bit of the result flags a producer whose data is not ready yet
    function automatic logic [`XLEN:0] bypass(input logic [`REG_AW-1:0] addr,
                                              input logic [`XLEN-1:0]   rf_val);
        logic [`XLEN:0] res;
        res = {1'b0, rf_val};
        if (addr != '0) begin
            if (ex1_pending_i && ex1_rd_i == addr) begin
                res = {!ex1_data_valid_i, ex1_data_i};
            end
            else if (ex2_pending_i && ex2_rd_i == addr) begin
                res = {!ex2_data_valid_i, ex2_data_i};
            end
        end
        return res;
    endfunction

    assign rf_raddr_a_o = iss_instr_q.rs1;
    assign rf_raddr_b_o = iss_instr_q.rs2;

    //////////////////////////////
    // Hazards
    //////////////////////////////

    always_comb begin
        fwd_a = bypass(iss_instr_q.rs1, rf_rdata_a_i);
        fwd_b = bypass(iss_instr_q.rs2, rf_rdata_b_i);
        data_hazard = fwd_a[`XLEN] || fwd_b[`XLEN];

        // Only one multiply may be in flight
        struct_hazard = !ex1_ready_i || (iss_instr_q.op == OP_MUL && mul_busy_i);

        pc_mismatch = iss_instr_q.pc != exp_pc_q;
        if (state_q == ST_NORMAL) begin
            control_hazard = pc_mismatch;
        end
        else begin
            control_hazard = !iss_instr_q.redirected;
        end
    end

    assign ex_issue      = iss_valid_q && !data_hazard && !struct_hazard && !control_hazard;
    // Wrong-path instructions leave the issue register without issuing
    assign iss_ready     = (!data_hazard && !struct_hazard) || control_hazard;
    assign fetch_ready_o = !iss_valid_q || iss_ready;

    assign instr_o = iss_instr_q;
    assign rs1_o   = fwd_a[`XLEN-1:0];
    assign rs2_o   = fwd_b[`XLEN-1:0];
    assign issue_o = ex_issue;

    //////////////////////////////
    // Expected PC and state
    //////////////////////////////

    assign npc = iss_instr_q.pc + `XLEN'(4);

    always_comb begin
        state_d  = state_q;
        exp_pc_d = exp_pc_q;

        unique case (state_q)
            ST_NORMAL: begin
                if (iss_valid_q && pc_mismatch) state_d = ST_MISPREDICT;
            end
            ST_MISPREDICT: begin
                if (iss_valid_q && iss_instr_q.redirected) state_d = ST_NORMAL;
            end
            default:;
        endcase

        if (ex_issue) begin
            unique case (iss_instr_q.op)
                OP_JAL:  exp_pc_d = alu_target_i;
                OP_BEQ:  exp_pc_d = alu_equal_i ? alu_target_i : npc;
                default: exp_pc_d = npc;
            endcase
        end
    end

    assign redirect_valid_o = state_q == ST_NORMAL && iss_valid_q && pc_mismatch;
    assign redirect_pc_o    = exp_pc_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            iss_valid_q <= 1'b0;
            state_q     <= ST_NORMAL;
            exp_pc_q    <= `BOOT_PC;
        end
        else begin
            if (fetch_valid_i && fetch_ready_o) begin
                iss_valid_q <= 1'b1;
            end
            else if (iss_ready) begin
                iss_valid_q <= 1'b0;
            end
            state_q  <= state_d;
            exp_pc_q <= exp_pc_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_valid_i && fetch_ready_o) begin
            iss_instr_q <= fetch_instr_i;
        end
    end

endmodule

//--- backend_mul_unit.sv
`timescale 1ns/1ps
`include "backend_params.svh"

module backend_mul_unit (
    input  logic             clk_i,
    input  logic             rst_ni,

    input  logic             start_i,
    input  logic [`XLEN-1:0] a_i,
    input  logic [`XLEN-1:0] b_i,

    output logic             busy_o,
    output logic             done_o,
    output logic [`XLEN-1:0] product_o
);

    logic                          busy_q;
    logic                          done_q;
    logic [$clog2(`MUL_STEPS)-1:0] step_q;
    logic [`XLEN-1:0]              a_q;
    logic [`XLEN-1:0]              b_q;
    logic [`XLEN-1:0]              acc_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            step_q <= '0;
        end
        else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                step_q <= '0;
            end
            else if (busy_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == ($clog2(`MUL_STEPS))'(`MUL_STEPS - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // One digit of the multiplier per step, low half of the product only
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            a_q   <= a_i;
            b_q   <= b_i;
            acc_q <= '0;
        end
        else if (busy_q) begin
            acc_q <= acc_q + a_q * `XLEN'(b_q[`XLEN/`MUL_STEPS-1:0]);
            a_q   <= a_q << (`XLEN / `MUL_STEPS);
            b_q   <= b_q >> (`XLEN / `MUL_STEPS);
        end
    end

    assign busy_o    = busy_q;
    assign done_o    = done_q;
    assign product_o = acc_q;

endmodule

//--- backend_params.svh
`ifndef BACKEND_PARAMS_SVH
`define BACKEND_PARAMS_SVH

// Data path and PC width
`define XLEN 32

// Architectural register file
`define NUM_REGS 32
`define REG_AW 5

// First fetch address after reset
`define BOOT_PC 32'h0000_0000

// Multiplier iterations, XLEN / MUL_STEPS bits are handled per step
`define MUL_STEPS 8

`endif

//--- backend_pkg.sv
`include "backend_params.svh"

package backend_pkg;

    // Operations kept in the reduced instruction set
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ADDI,
        OP_MUL,
        OP_BEQ,
        OP_JAL
    } op_e;

    // Where an execute stage takes its result from
    typedef enum logic [0:0] {
        FU_ALU,
        FU_MUL
    } fu_e;

    typedef enum logic [0:0] {
        ST_NORMAL,
        ST_MISPREDICT
    } issue_state_e;

    // Pre-decoded instruction as delivered by the frontend
    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        op_e                op;
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic [`XLEN-1:0]   imm;
        logic               redirected;
    } instr_t;

    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
    } commit_t;

endpackage

//--- backend_props.sv
`timescale 1ns/1ps

module backend_props (
    input logic clk_i,
    input logic rst_ni,
    input logic iss_valid_i,
    input logic ex_issue_i,
    input logic mul_start_i,
    input logic mul_busy_i,
    input logic fetch_hs_i,
    input logic commit_valid_i
);

    logic seen_fetch_q;

    // Set by the first fetch handshake after reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            seen_fetch_q <= 1'b0;
        end
        else if (fetch_hs_i) begin
            seen_fetch_q <= 1'b1;
        end
    end

    // An issued instruction leaves the issue register unless a new one arrives
    issue_empties_reg: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ex_issue_i && !fetch_hs_i |=> !iss_valid_i)
        else $error("issue register still valid after an issue without a new fetch");

    mul_start_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mul_start_i |-> !mul_busy_i)
        else $error("multiplier started while busy");

    no_commit_before_fetch: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !seen_fetch_q |-> !commit_valid_i)
        else $error("commit before any fetch handshake");

endmodule

bind backend_top backend_props props_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .iss_valid_i    (issue_i.iss_valid_q),
    .ex_issue_i     (issue),
    .mul_start_i    (mul_start),
    .mul_busy_i     (mul_busy),
    .fetch_hs_i     (fetch_valid_i && fetch_ready_o),
    .commit_valid_i (commit_valid_o)
);

//--- backend_reg_file.sv
`timescale 1ns/1ps
`include "backend_params.svh"

module backend_reg_file (
    input  logic               clk_i,
    input  logic               rst_ni,

    input  logic [`REG_AW-1:0] raddr_a_i,
    output logic [`XLEN-1:0]   rdata_a_o,
    input  logic [`REG_AW-1:0] raddr_b_i,
    output logic [`XLEN-1:0]   rdata_b_o,

    input  logic               we_i,
    input  logic [`REG_AW-1:0] waddr_i,
    input  logic [`XLEN-1:0]   wdata_i
);

    logic [`XLEN-1:0] regs_q [`NUM_REGS];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end
        else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // x0 is hardwired to zero
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- backend_tests.txt
# T name | I pc op rd rs1 rs2 imm | E pc rd data | D runs the test (all hex)
# op: 0 ADD 1 SUB 2 AND 3 OR 4 XOR 5 ADDI 6 MUL 7 BEQ 8 JAL
T alu_basic
I 00 5 01 00 00 00000005
I 04 5 02 00 00 0000000c
I 08 5 03 00 00 ffffffff
I 0c 5 05 00 00 00000100
I 10 0 04 01 02 00000000
I 14 1 06 01 02 00000000
I 18 2 07 03 05 00000000
I 1c 3 08 01 02 00000000
I 20 4 09 03 01 00000000
I 24 0 0a 0b 0c 00000000
E 00 01 00000005
E 04 02 0000000c
E 08 03 ffffffff
E 0c 05 00000100
E 10 04 00000011
E 14 06 fffffff9
E 18 07 00000100
E 1c 08 0000000d
E 20 09 fffffffa
E 24 0a 00000000
D
T bypass
I 00 5 01 00 00 00000003
I 04 0 02 01 01 00000000
I 08 0 03 02 01 00000000
I 0c 1 04 03 02 00000000
I 10 4 05 04 03 00000000
I 14 5 05 05 00 00000001
I 18 0 00 05 05 00000000
I 1c 0 06 00 05 00000000
E 00 01 00000003
E 04 02 00000006
E 08 03 00000009
E 0c 04 00000003
E 10 05 0000000a
E 14 05 0000000b
E 18 00 00000016
E 1c 06 0000000b
D
T mul
I 00 5 01 00 00 00000007
I 04 5 02 00 00 00000006
I 08 6 03 01 02 00000000
I 0c 0 04 03 01 00000000
I 10 5 05 00 00 00012345
I 14 6 06 05 05 00000000
I 18 5 07 00 00 00000001
I 1c 6 08 06 01 00000000
I 20 1 09 07 01 00000000
E 00 01 00000007
E 04 02 00000006
E 08 03 0000002a
E 0c 04 00000031
E 10 05 00012345
E 14 06 4b65f099
E 18 07 00000001
E 1c 08 0fc9942f
E 20 09 fffffffa
D
T branch_jump
I 00 5 01 00 00 00000004
I 04 5 02 00 00 00000004
I 08 7 00 01 02 00000010
I 0c 5 03 00 00 00000055
I 10 5 03 00 00 00000066
I 14 5 03 00 00 00000077
I 18 8 05 00 00 00000010
I 1c 5 06 00 00 00000001
I 20 5 06 00 00 00000002
I 24 5 06 00 00 00000003
I 28 0 07 05 01 00000000
I 2c 5 04 03 00 00000000
E 00 01 00000004
E 04 02 00000004
E 08 00 0000000c
E 18 05 0000001c
E 28 07 00000020
E 2c 04 00000000
D
T not_taken
I 00 5 01 00 00 00000001
I 04 5 02 00 00 00000002
I 08 7 00 01 02 00000020
I 0c 0 03 01 02 00000000
I 10 7 04 03 03 00000008
I 14 5 05 00 00 000000ee
I 18 3 06 03 04 00000000
E 00 01 00000001
E 04 02 00000002
E 08 00 0000000c
E 0c 03 00000003
E 10 04 00000014
E 18 06 00000017
D

//--- backend_top.sv
`timescale 1ns/1ps
`include "backend_params.svh"

module backend_top (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    input  logic                 fetch_valid_i,
    output logic                 fetch_ready_o,
    input  backend_pkg::instr_t  fetch_instr_i,

    output logic                 redirect_valid_o,
    output logic [`XLEN-1:0]     redirect_pc_o,

    output logic                 commit_valid_o,
    output backend_pkg::commit_t commit_o
);

    import backend_pkg::*;

    instr_t             instr;
    logic               issue;
    logic [`XLEN-1:0]   rs1;
    logic [`XLEN-1:0]   rs2;
    logic [`REG_AW-1:0] rf_raddr_a;
    logic [`REG_AW-1:0] rf_raddr_b;
    logic [`XLEN-1:0]   rf_rdata_a;
    logic [`XLEN-1:0]   rf_rdata_b;
    logic               rf_we;
    logic [`REG_AW-1:0] rf_waddr;
    logic [`XLEN-1:0]   rf_wdata;
    logic [`XLEN-1:0]   alu_result;
    logic [`XLEN-1:0]   alu_target;
    logic               alu_equal;
    logic               mul_start;
    logic               mul_busy;
    logic               mul_done;
    logic [`XLEN-1:0]   mul_product;
    logic               ex1_pending;
    logic               ex1_data_valid;
    logic [`REG_AW-1:0] ex1_rd;
    logic [`XLEN-1:0]   ex1_data;
    logic               ex2_pending;
    logic               ex2_data_valid;
    logic [`REG_AW-1:0] ex2_rd;
    logic [`XLEN-1:0]   ex2_data;
    logic               ex1_ready;

    backend_issue issue_i (
        .clk_i,
        .rst_ni,
        .fetch_valid_i,
        .fetch_ready_o,
        .fetch_instr_i,
        .rf_rdata_a_i     (rf_rdata_a),
        .rf_rdata_b_i     (rf_rdata_b),
        .rf_raddr_a_o     (rf_raddr_a),
        .rf_raddr_b_o     (rf_raddr_b),
        .ex1_pending_i    (ex1_pending),
        .ex1_data_valid_i (ex1_data_valid),
        .ex1_rd_i         (ex1_rd),
        .ex1_data_i       (ex1_data),
        .ex2_pending_i    (ex2_pending),
        .ex2_data_valid_i (ex2_data_valid),
        .ex2_rd_i         (ex2_rd),
        .ex2_data_i       (ex2_data),
        .ex1_ready_i      (ex1_ready),
        .mul_busy_i       (mul_busy),
        .alu_target_i     (alu_target),
        .alu_equal_i      (alu_equal),
        .instr_o          (instr),
        .rs1_o            (rs1),
        .rs2_o            (rs2),
        .issue_o          (issue),
        .redirect_valid_o,
        .redirect_pc_o
    );

    backend_alu alu_i (
        .op_i     (instr.op),
        .pc_i     (instr.pc),
        .imm_i    (instr.imm),
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .result_o (alu_result),
        .target_o (alu_target),
        .equal_o  (alu_equal)
    );

    // Multiplier starts with the issue of a MUL
    assign mul_start = issue && instr.op == OP_MUL;

    backend_mul_unit mul_i (
        .clk_i,
        .rst_ni,
        .start_i   (mul_start),
        .a_i       (rs1),
        .b_i       (rs2),
        .busy_o    (mul_busy),
        .done_o    (mul_done),
        .product_o (mul_product)
    );

    backend_exec_pipe exec_i (
        .clk_i,
        .rst_ni,
        .issue_i          (issue),
        .instr_i          (instr),
        .alu_result_i     (alu_result),
        .mul_done_i       (mul_done),
        .mul_product_i    (mul_product),
        .ex1_pending_o    (ex1_pending),
        .ex1_data_valid_o (ex1_data_valid),
        .ex1_rd_o         (ex1_rd),
        .ex1_data_o       (ex1_data),
        .ex2_pending_o    (ex2_pending),
        .ex2_data_valid_o (ex2_data_valid),
        .ex2_rd_o         (ex2_rd),
        .ex2_data_o       (ex2_data),
        .ex1_ready_o      (ex1_ready),
        .rf_we_o          (rf_we),
        .rf_waddr_o       (rf_waddr),
        .rf_wdata_o       (rf_wdata),
        .commit_valid_o,
        .commit_o
    );

    backend_reg_file reg_file_i (
        .clk_i,
        .rst_ni,
        .raddr_a_i (rf_raddr_a),
        .rdata_a_o (rf_rdata_a),
        .raddr_b_i (rf_raddr_b),
        .rdata_b_o (rf_rdata_b),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata)
    );

endmodule

//--- tb.f
+incdir+.
backend_pkg.sv
backend_reg_file.sv
backend_alu.sv
backend_mul_unit.sv
backend_issue.sv
backend_exec_pipe.sv
backend_top.sv
backend_props.sv
backend_checker.sv
tb_backend.sv

//--- tb_backend.sv
`timescale 1ns/1ps
`include "backend_params.svh"

module tb_backend;

    import backend_pkg::*;

    localparam string       TEST_FILE     = "backend_tests.txt";
    localparam int          RESET_CYCLES  = 10;
    localparam int          CYCLES_PER_OP = 60;
    localparam int          MEM_WORDS     = 64;
    localparam logic [31:0] SEED_INIT     = 32'h8406d74e;

    logic              clk_i;
    logic              rst_ni;
    logic              fetch_valid_i;
    logic              fetch_ready_o;
    instr_t            fetch_instr_i;
    logic              redirect_valid_o;
    logic [`XLEN-1:0]  redirect_pc_o;
    logic              commit_valid_o;
    commit_t           commit_o;

    instr_t            imem [MEM_WORDS];
    logic              imem_valid [MEM_WORDS];
    logic              running;
    logic              timed_out;
    logic              hs;
    logic              gap;
    logic [`XLEN-1:0]  fetch_pc;
    logic              fetch_redir;
    integer            seed;
    integer            fd;
    integer            n;
    integer            n_exp;
    integer            cycles;
    logic              file_done;
    string             tag;
    string             name;
    logic [8*256-1:0]  line;
    logic [31:0]       f_pc;
    logic [31:0]       f_op;
    logic [31:0]       f_rd;
    logic [31:0]       f_rs1;
    logic [31:0]       f_rs2;
    logic [31:0]       f_imm;

    backend_top backend_top_i (.*);

    backend_checker chk (
        .clk_i,
        .rst_ni,
        .commit_valid_i   (commit_valid_o),
        .commit_i         (commit_o),
        .redirect_valid_i (redirect_valid_o),
        .redirect_pc_i    (redirect_pc_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    //////////////////////////////
    // Fetch model
    //////////////////////////////

    // Predicts not taken, follows the redirect port
    always @(posedge clk_i) begin
        hs = fetch_valid_i && fetch_ready_o;
        #1;
        if (!running) begin
            fetch_valid_i = 1'b0;
            fetch_pc      = `BOOT_PC;
            fetch_redir   = 1'b0;
        end
        else begin
            if (hs) begin
                fetch_pc    = fetch_pc + 4;
                fetch_redir = 1'b0;
            end
            if (redirect_valid_o) begin
                fetch_pc    = redirect_pc_o;
                fetch_redir = 1'b1;
            end
            gap = ($random(seed) & 3) == 0;
            if (fetch_pc < 4 * MEM_WORDS && imem_valid[fetch_pc[7:2]] && !gap) begin
                fetch_instr_i            = imem[fetch_pc[7:2]];
                fetch_instr_i.redirected = fetch_redir;
                fetch_valid_i            = 1'b1;
            end
            else begin
                fetch_valid_i = 1'b0;
            end
        end
    end

    task automatic clear_imem();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem_valid[i] = 1'b0;
            imem[i]       = '0;
        end
    endtask

    task automatic run_test(input int n_commits);
        int limit;
        @(posedge clk_i);
        #1 rst_ni = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1 rst_ni = 1'b1;
        @(posedge clk_i);
        running = 1'b1;
        limit   = CYCLES_PER_OP * n_commits + RESET_CYCLES;
        cycles  = 0;
        while (chk.seen_count < n_commits && cycles < limit) begin
            @(posedge clk_i);
            cycles++;
        end
        if (chk.seen_count < n_commits) begin
            $display("Timeout: test %s did not finish within %0d cycles", name, limit);
            running   = 1'b0;
            timed_out = 1'b1;
        end
        else begin
            // Give extra commits a chance to show up
            repeat (RESET_CYCLES) @(posedge clk_i);
            running = 1'b0;
            chk.end_test();
        end
    endtask

    initial begin
        rst_ni        = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_instr_i = '0;
        running       = 1'b0;
        timed_out     = 1'b0;
        fetch_pc      = `BOOT_PC;
        fetch_redir   = 1'b0;
        seed          = SEED_INIT;
        n_exp         = 0;
        file_done     = 1'b0;
        clear_imem();
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Could not open %s", TEST_FILE);
            $display("Test failures found");
            $finish;
        end
        else begin
            while (!file_done && !timed_out) begin
                n = $fscanf(fd, "%s", tag);
                if (n != 1) begin
                    file_done = 1'b1;
                end
                else if (tag == "#") begin
                    n = $fgets(line, fd);
                end
                else if (tag == "T") begin
                    n = $fscanf(fd, "%s", name);
                    clear_imem();
                    chk.start_test(name);
                    n_exp = 0;
                end
                else if (tag == "I") begin
                    n = $fscanf(fd, "%h %h %h %h %h %h", f_pc, f_op, f_rd, f_rs1, f_rs2, f_imm);
                    imem[f_pc[7:2]].pc  = f_pc;
                    imem[f_pc[7:2]].op  = op_e'(f_op[3:0]);
                    imem[f_pc[7:2]].rd  = f_rd[`REG_AW-1:0];
                    imem[f_pc[7:2]].rs1 = f_rs1[`REG_AW-1:0];
                    imem[f_pc[7:2]].rs2 = f_rs2[`REG_AW-1:0];
                    imem[f_pc[7:2]].imm = f_imm;
                    imem_valid[f_pc[7:2]] = 1'b1;
                end
                else if (tag == "E") begin
                    n = $fscanf(fd, "%h %h %h", f_pc, f_rd, f_imm);
                    chk.add_expect(f_pc, f_rd[`REG_AW-1:0], f_imm);
                    n_exp++;
                end
                else if (tag == "D") begin
                    run_test(n_exp);
                end
            end
            $fclose(fd);
            chk.print_summary();
            if (!timed_out && chk.error_total == 0 && chk.tests_run > 0) begin
                $display("All tests passed!");
            end
            else begin
                $display("Test failures found");
            end
            $finish;
        end
    end

endmodule
